//--- rtl/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ######################################################################
// Fetch stage configuration
// ######################################################################

// First fetch address after reset
`define FETCH_RESET_PC    32'h8000_0000

// Cacheable window, base inclusive and limit exclusive
`define FETCH_CACHE_BASE  32'h8000_0000
`define FETCH_CACHE_LIMIT 32'h8010_0000

// Cache geometry, line count must be a power of two
`define FETCH_LINES       16
`define FETCH_LINE_WORDS  4

// Derived sizes
`define FETCH_LINE_BYTES  (`FETCH_LINE_WORDS * 4)
`define FETCH_INDEX_BITS  $clog2(`FETCH_LINES)

`endif

//--- rtl/fetch_pkg.sv
package fetch_pkg;

	// AXI burst type encodings
	localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
	localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

	// Packet handed to decode
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_packet_t;

	// AXI read address channel payload
	typedef struct packed {
		logic [31:0] addr;
		logic [1:0]  burst;
		logic [3:0]  len;
	} axi_ar_t;

	// AXI read data channel payload, rresp not carried
	typedef struct packed {
		logic [31:0] data;
		logic        last;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] addr;
	} cache_lookup_t;

	// One refill word, last closes the line
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        last;
	} cache_fill_t;

	typedef struct packed {
		logic        hit;
		logic [31:0] data;
	} cache_result_t;

endpackage

//--- rtl/icache.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module icache (
	input  logic                     clock,
	input  logic                     rst_n,
	// Lookup request, answered one cycle later
	input  logic                     lookup_valid,
	input  fetch_pkg::cache_lookup_t lookup,
	output logic                     result_valid,
	output fetch_pkg::cache_result_t result,
	// Refill writes, one word per beat
	input  logic                     fill_valid,
	input  fetch_pkg::cache_fill_t   fill
);
	import fetch_pkg::*;

	localparam int IDX_W  = `FETCH_INDEX_BITS;
	localparam int WORD_W = $clog2(`FETCH_LINE_WORDS);
	localparam int OFF_W  = WORD_W + 2;
	localparam int TAG_W  = 32 - OFF_W - IDX_W;

	// ######################################################################
	// Storage
	// ######################################################################

	logic [31:0]             data_mem [`FETCH_LINES * `FETCH_LINE_WORDS];
	logic [TAG_W-1:0]        tag_mem  [`FETCH_LINES];
	logic [`FETCH_LINES-1:0] line_valid;

	// Address fields
	logic [IDX_W-1:0]  lk_idx;
	logic [WORD_W-1:0] lk_word;
	logic [TAG_W-1:0]  lk_tag;
	logic [IDX_W-1:0]  fl_idx;
	logic [WORD_W-1:0] fl_word;
	logic [TAG_W-1:0]  fl_tag;

	cache_result_t result_d;

	assign lk_idx  = lookup.addr[OFF_W +: IDX_W];
	assign lk_word = lookup.addr[2 +: WORD_W];
	assign lk_tag  = lookup.addr[31 -: TAG_W];

	assign fl_idx  = fill.addr[OFF_W +: IDX_W];
	assign fl_word = fill.addr[2 +: WORD_W];
	assign fl_tag  = fill.addr[31 -: TAG_W];

	// ######################################################################
	// Lookup
	// ######################################################################

	// Tag compare against the addressed line
	always_comb begin
		result_d.hit  = line_valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
		result_d.data = data_mem[{lk_idx, lk_word}];
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			result <= result_d;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= lookup_valid;
		end
	end

	// ######################################################################
	// Refill
	// ######################################################################

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[{fl_idx, fl_word}] <= fill.data;
			if (fill.last) begin
				tag_mem[fl_idx] <= fl_tag;
			end
		end
	end

	// Line goes invalid on its first refill word and valid again on the last
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			line_valid <= '0;
		end else if (fill_valid) begin
			line_valid[fl_idx] <= fill.last;
		end
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_unit (
	input  logic                     clock,
	input  logic                     rst_n,
	// AXI read address
	output fetch_pkg::axi_ar_t       ar,
	output logic                     ar_valid,
	input  logic                     ar_ready,
	// AXI read data
	input  fetch_pkg::axi_r_t        r,
	input  logic                     r_valid,
	// Cache ports
	output logic                     lookup_valid,
	output fetch_pkg::cache_lookup_t lookup,
	input  logic                     result_valid,
	input  fetch_pkg::cache_result_t result,
	output logic                     fill_valid,
	output fetch_pkg::cache_fill_t   fill,
	// Redirect strobe
	input  logic                     redirect_valid,
	input  logic [31:0]              redirect_pc,
	// Decode side
	output fetch_pkg::fetch_packet_t dec_packet,
	output logic                     dec_valid,
	input  logic                     dec_ready
);
	import fetch_pkg::*;

	localparam logic [31:0] LINE_BYTES = `FETCH_LINE_BYTES;
	localparam logic [3:0]  BURST_LEN  = 4'(`FETCH_LINE_WORDS - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_ADDR,
		S_DATA,
		S_OUT
	} state_t;

	state_t        state;
	logic          run;
	logic [31:0]   pc;
	logic          cached_q;
	logic          redirect_pending;
	logic [31:0]   beat_addr;
	axi_ar_t       ar_q;
	logic          ar_valid_q;
	fetch_packet_t pkt;
	logic          dec_valid_q;

	logic          r_ready;
	logic          transfer;
	logic          start;
	logic [31:0]   fetch_pc;
	logic          fetch_cached;
	logic [31:0]   line_base;
	logic          beat;
	logic          beat_end;
	logic          hit_done;
	logic          miss;
	logic          deliver_beat;

	function automatic logic in_window(input logic [31:0] addr);
		return (addr >= `FETCH_CACHE_BASE) && (addr < `FETCH_CACHE_LIMIT);
	endfunction

	// ######################################################################
	// Fetch start and event decode
	// ######################################################################

	// Read data is always accepted
	assign r_ready  = 1'b1;
	assign transfer = dec_valid_q & dec_ready;

	// New fetch after reset, after a dropped fetch, or when the output empties
	assign start = (state == S_IDLE && run) || (state == S_OUT && (transfer || redirect_valid));

	always_comb begin
		if (redirect_valid)
			fetch_pc = redirect_pc;
		else if (state == S_OUT)
			fetch_pc = pc + 32'd4;
		else
			fetch_pc = pc;
	end

	assign fetch_cached = in_window(fetch_pc);
	assign line_base    = pc & ~(LINE_BYTES - 32'd1);

	assign hit_done = (state == S_LOOKUP) && result_valid && result.hit && !redirect_valid;
	assign miss     = (state == S_LOOKUP) && result_valid && !result.hit && !redirect_valid;

	assign beat     = (state == S_DATA) && r_valid && r_ready;
	assign beat_end = beat && (r.last || !cached_q);

	// Any refill beat matching pc is handed on, also pc + 4 after an early transfer
	assign deliver_beat = beat && !redirect_pending && !redirect_valid && !dec_valid_q &&
		(!cached_q || beat_addr == pc);

	// Lookup is issued in the start cycle itself
	assign lookup_valid = start & fetch_cached;
	assign lookup.addr  = fetch_pc;

	// Refill words go straight to the cache
	assign fill_valid = beat & cached_q;
	assign fill       = '{addr: beat_addr, data: r.data, last: r.last};

	assign ar         = ar_q;
	assign ar_valid   = ar_valid_q;
	assign dec_packet = pkt;
	assign dec_valid  = dec_valid_q;

	// ######################################################################
	// Control state
	// ######################################################################

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state            <= S_IDLE;
			run              <= 1'b0;
			pc               <= `FETCH_RESET_PC;
			cached_q         <= 1'b0;
			redirect_pending <= 1'b0;
			ar_valid_q       <= 1'b0;
			dec_valid_q      <= 1'b0;
		end else begin
			run <= 1'b1;
			if (start) begin
				pc               <= fetch_pc;
				cached_q         <= fetch_cached;
				redirect_pending <= 1'b0;
				dec_valid_q      <= 1'b0;
				if (fetch_cached) begin
					state <= S_LOOKUP;
				end else begin
					ar_valid_q <= 1'b1;
					state      <= S_ADDR;
				end
			end else begin
				case (state)
					S_LOOKUP: begin
						// Stale lookup result is simply ignored
						if (redirect_valid) begin
							pc    <= redirect_pc;
							state <= S_IDLE;
						end else if (hit_done) begin
							dec_valid_q <= 1'b1;
							state       <= S_OUT;
						end else if (miss) begin
							ar_valid_q <= 1'b1;
							state      <= S_ADDR;
						end
					end
					S_ADDR: begin
						// Request must hold, so the redirect only marks the fetch dead
						if (redirect_valid) begin
							pc               <= redirect_pc;
							redirect_pending <= 1'b1;
						end
						if (ar_ready) begin
							ar_valid_q <= 1'b0;
							state      <= S_DATA;
						end
					end
					S_DATA: begin
						if (redirect_valid) begin
							pc               <= redirect_pc;
							redirect_pending <= 1'b1;
							dec_valid_q      <= 1'b0;
						end else if (transfer) begin
							pc          <= pc + 32'd4;
							dec_valid_q <= 1'b0;
						end else if (deliver_beat) begin
							dec_valid_q <= 1'b1;
						end
						if (beat_end) begin
							redirect_pending <= 1'b0;
							if (redirect_valid || redirect_pending)
								state <= S_IDLE;
							else if (deliver_beat || (dec_valid_q && !transfer))
								state <= S_OUT;
							else
								state <= S_IDLE;
						end
					end
					default: begin
						// Idle before the first start, output held under back-pressure
						state <= state;
					end
				endcase
			end
		end
	end

	// ######################################################################
	// Payload registers
	// ######################################################################

	always_ff @(posedge clock) begin
		if (start && !fetch_cached) begin
			ar_q <= '{addr: fetch_pc, burst: AXI_BURST_FIXED, len: 4'd0};
		end else if (miss) begin
			ar_q      <= '{addr: line_base, burst: AXI_BURST_INCR, len: BURST_LEN};
			beat_addr <= line_base;
		end
		if (beat) begin
			beat_addr <= beat_addr + 32'd4;
		end
		if (hit_done) begin
			pkt <= '{pc: pc, inst: result.data};
		end else if (deliver_beat) begin
			pkt <= '{pc: pc, inst: r.data};
		end
	end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
	input  logic                     clock,
	input  logic                     rst_n,
	// AXI read port
	output fetch_pkg::axi_ar_t       ar,
	output logic                     ar_valid,
	input  logic                     ar_ready,
	input  fetch_pkg::axi_r_t        r,
	input  logic                     r_valid,
	// Redirect
	input  logic                     redirect_valid,
	input  logic [31:0]              redirect_pc,
	// Decode
	output fetch_pkg::fetch_packet_t dec_packet,
	output logic                     dec_valid,
	input  logic                     dec_ready
);
	import fetch_pkg::*;

	// Fetch unit to cache
	logic          lookup_valid;
	cache_lookup_t lookup;
	logic          result_valid;
	cache_result_t result;
	logic          fill_valid;
	cache_fill_t   fill;

	fetch_unit u_fetch_unit (
		.clock          (clock),
		.rst_n          (rst_n),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.r              (r),
		.r_valid        (r_valid),
		.lookup_valid   (lookup_valid),
		.lookup         (lookup),
		.result_valid   (result_valid),
		.result         (result),
		.fill_valid     (fill_valid),
		.fill           (fill),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.dec_packet     (dec_packet),
		.dec_valid      (dec_valid),
		.dec_ready      (dec_ready)
	);

	icache u_icache (
		.clock        (clock),
		.rst_n        (rst_n),
		.lookup_valid (lookup_valid),
		.lookup       (lookup),
		.result_valid (result_valid),
		.result       (result),
		.fill_valid   (fill_valid),
		.fill         (fill)
	);

endmodule

//--- testbench/fetch_assert.sv
`timescale 1ns/10ps

module fetch_assert (
	input logic                     clock,
	input logic                     rst_n,
	input fetch_pkg::axi_ar_t       ar,
	input logic                     ar_valid,
	input logic                     ar_ready,
	input logic                     lookup_valid,
	input logic                     fill_valid,
	input logic                     redirect_valid,
	input fetch_pkg::fetch_packet_t dec_packet,
	input logic                     dec_valid,
	input logic                     dec_ready
);
	int failures = 0;

	// Read address holds until accepted
	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			$error("AXI read address dropped or changed before ar_ready");
			failures++;
		end

	// Packet holds under back-pressure unless a redirect drops it
	dec_hold: assert property (@(posedge clock) disable iff (!rst_n)
		dec_valid && !dec_ready && !redirect_valid |=> dec_valid && $stable(dec_packet))
		else begin
			$error("Decode packet dropped or changed while dec_ready was low");
			failures++;
		end

	reset_quiet: assert property (@(posedge clock)
		!rst_n |-> !dec_valid && !ar_valid && !lookup_valid && !fill_valid)
		else begin
			$error("Valid output raised during reset");
			failures++;
		end

endmodule

//--- testbench/fetch_checker.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_checker (
	input  logic                     clock,
	input  logic                     rst_n,
	input  int                       test_id,
	input  fetch_pkg::axi_ar_t       ar,
	input  logic                     ar_valid,
	input  logic                     ar_ready,
	input  logic                     redirect_valid,
	input  logic [31:0]              redirect_pc,
	input  fetch_pkg::fetch_packet_t dec_packet,
	input  logic                     dec_valid,
	input  logic                     dec_ready,
	output int                       packets,
	output int                       requests,
	output int                       errors
);
	import fetch_pkg::*;

	localparam logic [31:0] MEM_MIX = 32'h9e37_79b9;

	logic [31:0]             expect_pc;
	// Last single-beat read address
	logic [31:0]             single_addr;
	// Fetch address behind the current AXI request
	logic [31:0]             req_pc;
	logic [31:0]             req_base;
	logic                    ar_waiting;
	logic [31:0]             line_held [`FETCH_LINES];
	logic [`FETCH_LINES-1:0] held_valid;
	logic [31:0]             req_line;
	int                      req_idx;
	int                      cur_test;
	int                      test_packets;
	int                      test_requests;
	int                      test_errors;

	// Memory contents, a fixed mixing of the whole address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] x;
		x = (addr ^ MEM_MIX) * 32'h85eb_ca6b;
		return x ^ {x[15:0], x[31:16]};
	endfunction

	function automatic logic cacheable(input logic [31:0] addr);
		return addr >= `FETCH_CACHE_BASE && addr < `FETCH_CACHE_LIMIT;
	endfunction

	function automatic string test_label(input int id);
		case (id)
			0: return "reset";
			1: return "sequential";
			2: return "reuse";
			3: return "uncached";
			4: return "redirect";
			5: return "backpressure";
			default: return "done";
		endcase
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		$display("MISMATCH %s %s: expected %08h, actual %08h", test_label(cur_test), what,
			exp_v, act_v);
		test_errors++;
		errors++;
	endtask

	task automatic fault(input string what);
		$display("ERROR %s: %s", test_label(cur_test), what);
		test_errors++;
		errors++;
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			if (dec_valid || ar_valid)
				fault("decode or AXI address valid is high during reset");
			expect_pc  = `FETCH_RESET_PC;
			held_valid = '0;
			ar_waiting = 1'b0;
			packets    = 0;
			requests   = 0;
			errors     = test_errors;
			cur_test   = test_id;
		end else begin
			// Transfer first, a redirect in the same cycle comes after it
			if (dec_valid && dec_ready) begin
				packets++;
				test_packets++;
				if (dec_packet.pc !== expect_pc)
					mismatch("pc", expect_pc, dec_packet.pc);
				if (dec_packet.inst !== mem_word(expect_pc))
					mismatch("instruction", mem_word(expect_pc), dec_packet.inst);
				if (!cacheable(expect_pc) && single_addr !== expect_pc)
					mismatch("single read address", expect_pc, single_addr);
				expect_pc = expect_pc + 32'd4;
			end
			// A new request always belongs to the next pc in program order
			if (ar_valid && !ar_waiting)
				req_pc = expect_pc;
			if (ar_valid && ar_ready) begin
				requests++;
				test_requests++;
				req_line = ar.addr / `FETCH_LINE_BYTES;
				req_idx  = req_line % `FETCH_LINES;
				req_base = (req_pc / `FETCH_LINE_BYTES) * `FETCH_LINE_BYTES;
				if (cacheable(req_pc)) begin
					if (ar.addr !== req_base)
						mismatch("burst address", req_base, ar.addr);
					if (ar.burst !== AXI_BURST_INCR)
						mismatch("burst type", 32'(AXI_BURST_INCR), 32'(ar.burst));
					if (32'(ar.len) != `FETCH_LINE_WORDS - 1)
						mismatch("burst length", `FETCH_LINE_WORDS - 1, 32'(ar.len));
					if (held_valid[req_idx] && line_held[req_idx] == req_line)
						fault("refill requested for a line that is still in the cache");
					held_valid[req_idx] = 1'b1;
					line_held[req_idx]  = req_line;
				end else begin
					if (ar.addr !== req_pc)
						mismatch("single read address", req_pc, ar.addr);
					if (ar.len !== 4'd0)
						mismatch("single read length", 32'd0, 32'(ar.len));
					single_addr = ar.addr;
				end
			end
			ar_waiting = ar_valid && !ar_ready;
			if (redirect_valid)
				expect_pc = redirect_pc;
			if (test_id != cur_test) begin
				$display("test %s: %0d packets, %0d AXI requests, %0d errors",
					test_label(cur_test), test_packets, test_requests, test_errors);
				cur_test      = test_id;
				test_packets  = 0;
				test_requests = 0;
				test_errors   = 0;
			end
		end
	end

	initial begin
		test_packets  = 0;
		test_requests = 0;
		test_errors   = 0;
		single_addr   = '0;
	end

endmodule

//--- testbench/tb_fetch.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch;
	import fetch_pkg::*;

	localparam logic [31:0] SEED = 32'h5547c4d8;
	// Worst cycles per fetch through the memory model
	localparam int MEM_LATENCY  = 16;
	localparam int LEN_RESET    = 1;
	localparam int LEN_SEQ      = 64;
	localparam int LEN_REUSE    = 16;
	localparam int LEN_UNCACHED = 8;
	localparam int LEN_REDIRECT = 40;
	localparam int LEN_STALL    = 64;
	localparam int CYCLE_LIMIT  = 8 * MEM_LATENCY *
		(LEN_RESET + LEN_SEQ + LEN_REUSE + LEN_UNCACHED + LEN_REDIRECT + LEN_STALL);

	logic          clock;
	logic          rst_n;
	axi_ar_t       ar;
	logic          ar_valid;
	logic          ar_ready = 1'b0;
	axi_r_t        r = '0;
	logic          r_valid = 1'b0;
	logic          redirect_valid;
	logic [31:0]   redirect_pc;
	fetch_packet_t dec_packet;
	logic          dec_valid;
	logic          dec_ready = 1'b0;

	int          test_id;
	int          stall_rate;
	int          packets;
	int          requests;
	int          errors;
	int          failures;
	int          cycles = 0;
	int          beats_left = 0;
	int          ar_delay = 0;
	logic [31:0] rd_addr = '0;

	fetch_top UUT (.*);

	fetch_checker chk (
		.clock          (clock),
		.rst_n          (rst_n),
		.test_id        (test_id),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.dec_packet     (dec_packet),
		.dec_valid      (dec_valid),
		.dec_ready      (dec_ready),
		.packets        (packets),
		.requests       (requests),
		.errors         (errors)
	);

	bind fetch_unit fetch_assert hs_checks (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ######################################################################
	// AXI read memory and decode consumer
	// ######################################################################

	always @(negedge clock) begin
		ar_ready <= 1'b0;
		r_valid  <= 1'b0;
		if (beats_left > 0) begin
			// Beats in address order, a gap now and then
			if ($urandom % 4 != 0) begin
				r_valid    <= 1'b1;
				r          <= '{data: chk.mem_word(rd_addr), last: beats_left == 1};
				rd_addr    <= rd_addr + 32'd4;
				beats_left <= beats_left - 1;
			end
		end else if (rst_n && ar_valid && !ar_ready) begin
			if (ar_delay == 0) begin
				ar_ready   <= 1'b1;
				rd_addr    <= ar.addr;
				beats_left <= 32'(ar.len) + 1;
				ar_delay   <= $urandom % 4;
			end else begin
				ar_delay <= ar_delay - 1;
			end
		end
	end

	always @(negedge clock) begin
		dec_ready <= ($urandom % 100) >= stall_rate;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ######################################################################
	// Test sequence
	// ######################################################################

	task automatic wait_packets(input int count);
		int target;
		target = packets + count;
		while (packets < target)
			@(negedge clock);
	endtask

	task automatic strobe_redirect(input logic [31:0] target);
		redirect_pc    = target;
		redirect_valid = 1'b1;
		@(negedge clock);
		redirect_valid = 1'b0;
	endtask

	// Mostly cacheable targets, some uncached
	function automatic logic [31:0] pick_target();
		if ($urandom % 4 == 0)
			return 32'h0000_2000 + ($urandom % 64) * 4;
		return `FETCH_CACHE_BASE + ($urandom % 1024) * 4;
	endfunction

	initial begin
		void'($urandom(SEED));
		rst_n          = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		test_id        = 0;
		stall_rate     = 0;
		repeat (16) @(negedge clock);
		rst_n = 1'b1;
		wait_packets(LEN_RESET);
		test_id = 1;
		wait_packets(LEN_SEQ);
		// Line 4 survives the sequential run, line 0 does not
		test_id = 2;
		strobe_redirect(`FETCH_RESET_PC + 32'h40);
		wait_packets(LEN_REUSE);
		test_id = 3;
		strobe_redirect(32'h0000_1000);
		wait_packets(LEN_UNCACHED);
		test_id    = 4;
		stall_rate = 30;
		repeat (LEN_REDIRECT) begin
			repeat ($urandom % 24) @(negedge clock);
			strobe_redirect(pick_target());
		end
		wait_packets(4);
		test_id    = 5;
		stall_rate = 50;
		strobe_redirect(`FETCH_CACHE_BASE + 32'h1000);
		wait_packets(LEN_STALL);
		test_id = 6;
		repeat (2) @(negedge clock);
		failures = UUT.u_fetch_unit.hs_checks.failures;
		$display("%0d packets, %0d AXI requests, %0d check errors, %0d assertion failures",
			packets, requests, errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
testbench/fetch_assert.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_fetch
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --assert --timing
ERROR_LIMIT ?= 100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
